//--- csr_pkg.sv
// Shared widths, CSR address map, identity constants and structs for the CSR data block
package csr_pkg;

    // Core geometry
    localparam int NUM_WARPS       = 4;
    localparam int NUM_THREADS     = 4;
    localparam int NUM_CORES_TOTAL = 4;
    localparam int NUM_FPU_BLOCKS  = 2;

    localparam int XLEN          = 32;
    localparam int PERF_CTR_BITS = 44;
    localparam int WID_BITS      = $clog2(NUM_WARPS);
    localparam int FFLAGS_BITS   = 5;
    localparam int FRM_BITS      = 3;

    typedef logic [11:0]                          csr_addr_t;
    typedef logic [XLEN-1:0]                      csr_word_t;
    typedef logic [WID_BITS-1:0]                  wid_t;
    typedef logic [FFLAGS_BITS-1:0]               fflags_t;
    typedef logic [FRM_BITS-1:0]                  frm_t;
    // frm sits above fflags
    typedef logic [FRM_BITS+FFLAGS_BITS-1:0]      fcsr_t;
    typedef logic [PERF_CTR_BITS-1:0]             perf_ctr_t;
    typedef logic [NUM_WARPS-1:0]                 warp_mask_t;
    typedef logic [NUM_THREADS-1:0]               thread_mask_t;

    localparam csr_word_t VENDOR_ID = 32'h0000_0056;
    localparam csr_word_t ARCH_ID   = 32'h0000_0001;
    localparam csr_word_t IMPL_ID   = 32'h0000_0002;

    // MXL in the top two bits, then the I, M and F extension bits
    localparam csr_word_t MISA_VALUE = csr_word_t'(($clog2(XLEN) - 4) << (XLEN - 2))
                                     | (csr_word_t'(1) << 8)
                                     | (csr_word_t'(1) << 12)
                                     | (csr_word_t'(1) << 5);

    // Floating point
    localparam csr_addr_t CSR_FFLAGS      = 12'h001;
    localparam csr_addr_t CSR_FRM         = 12'h002;
    localparam csr_addr_t CSR_FCSR        = 12'h003;

    // Identity
    localparam csr_addr_t CSR_MVENDORID   = 12'hF11;
    localparam csr_addr_t CSR_MARCHID     = 12'hF12;
    localparam csr_addr_t CSR_MIMPID      = 12'hF13;
    localparam csr_addr_t CSR_MISA        = 12'h301;

    // Counters
    localparam csr_addr_t CSR_MCYCLE      = 12'hB00;
    localparam csr_addr_t CSR_MCYCLE_H    = 12'hB80;
    localparam csr_addr_t CSR_MINSTRET    = 12'hB02;
    localparam csr_addr_t CSR_MINSTRET_H  = 12'hB82;

    // Stubs that accept writes and read zero
    localparam csr_addr_t CSR_SATP        = 12'h180;
    localparam csr_addr_t CSR_MSTATUS     = 12'h300;
    localparam csr_addr_t CSR_MEDELEG     = 12'h302;
    localparam csr_addr_t CSR_MIDELEG     = 12'h303;
    localparam csr_addr_t CSR_MIE         = 12'h304;
    localparam csr_addr_t CSR_MTVEC       = 12'h305;
    localparam csr_addr_t CSR_MEPC        = 12'h341;
    localparam csr_addr_t CSR_PMPCFG0     = 12'h3A0;
    localparam csr_addr_t CSR_PMPADDR0    = 12'h3B0;
    localparam csr_addr_t CSR_MNSTATUS    = 12'h744;

    // Core specific
    localparam csr_addr_t CSR_WARP_ID     = 12'hCC1;
    localparam csr_addr_t CSR_CORE_ID     = 12'hCC2;
    localparam csr_addr_t CSR_WARP_MASK   = 12'hCC3;
    localparam csr_addr_t CSR_THREAD_MASK = 12'hCC4;
    localparam csr_addr_t CSR_NUM_THREADS = 12'hFC0;
    localparam csr_addr_t CSR_NUM_WARPS   = 12'hFC1;
    localparam csr_addr_t CSR_NUM_CORES   = 12'hFC2;

    // Performance-monitor windows
    localparam csr_addr_t CSR_MPM_USER    = 12'hB00;
    localparam csr_addr_t CSR_MPM_USER_H  = 12'hB80;
    localparam int        MPM_WINDOW      = 32;

    typedef struct packed {
        logic      enable;
        wid_t      wid;
        csr_addr_t addr;
        csr_word_t data;
    } csr_write_t;

    typedef struct packed {
        logic    valid;
        wid_t    wid;
        fflags_t fflags;
    } fpu_flags_t;

    typedef struct packed {
        fflags_t set_flags;
        logic    load_flags;
        logic    load_frm;
        fflags_t new_flags;
        frm_t    new_frm;
    } fcsr_cmd_t;

endpackage

//--- fcsr_update.sv
// Turns CSR writes and FPU flag reports into one fcsr update command per warp
`timescale 1ns/1ps

module fcsr_update import csr_pkg::*; (
    input  csr_write_t                      csr_wr,
    input  fpu_flags_t [NUM_FPU_BLOCKS-1:0] fpu_flags,
    output fcsr_cmd_t  [NUM_WARPS-1:0]      cmds,
    output logic                            write_error
);

    logic wr_flags;
    logic wr_frm;
    logic wr_stub;
    frm_t wr_frm_val;

    // Address decode shared by all warps
    always_comb begin
        wr_flags   = 1'b0;
        wr_frm     = 1'b0;
        wr_stub    = 1'b0;
        wr_frm_val = csr_wr.data[FRM_BITS-1:0];
        case (csr_wr.addr)
            CSR_FFLAGS: wr_flags = 1'b1;
            CSR_FRM:    wr_frm = 1'b1;
            CSR_FCSR: begin
                wr_flags   = 1'b1;
                wr_frm     = 1'b1;
                wr_frm_val = csr_wr.data[FFLAGS_BITS +: FRM_BITS];
            end
            CSR_SATP,
            CSR_MSTATUS,
            CSR_MNSTATUS,
            CSR_MEDELEG,
            CSR_MIDELEG,
            CSR_MIE,
            CSR_MTVEC,
            CSR_MEPC,
            CSR_PMPCFG0,
            CSR_PMPADDR0: wr_stub = 1'b1;
            default: ;
        endcase
    end

    assign write_error = csr_wr.enable && !(wr_flags || wr_frm || wr_stub);

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            logic hit;
            hit = csr_wr.enable && (csr_wr.wid == wid_t'(w));

            cmds[w].set_flags = '0;
            // Several units may report on the same warp
            for (int f = 0; f < NUM_FPU_BLOCKS; f++) begin
                if (fpu_flags[f].valid && (fpu_flags[f].wid == wid_t'(w))) begin
                    cmds[w].set_flags = cmds[w].set_flags | fpu_flags[f].fflags;
                end
            end

            cmds[w].load_flags = hit && wr_flags;
            cmds[w].load_frm   = hit && wr_frm;
            cmds[w].new_flags  = csr_wr.data[FFLAGS_BITS-1:0];
            cmds[w].new_frm    = wr_frm_val;
        end
    end

endmodule

//--- fcsr_regfile.sv
// Per-warp fcsr storage with rounding-mode lookup for the floating-point units
`timescale 1ns/1ps

module fcsr_regfile import csr_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  fcsr_cmd_t [NUM_WARPS-1:0]       cmds,
    input  wid_t      [NUM_FPU_BLOCKS-1:0]  fpu_rd_wid,
    output fcsr_t     [NUM_WARPS-1:0]       fcsr,
    output frm_t      [NUM_FPU_BLOCKS-1:0]  fpu_frm
);

    fcsr_t [NUM_WARPS-1:0] fcsr_n;

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            fflags_t flags_n;
            frm_t    frm_n;
            // A CSR write overrides flags reported in the same cycle
            if (cmds[w].load_flags) begin
                flags_n = cmds[w].new_flags;
            end else begin
                flags_n = fcsr[w][FFLAGS_BITS-1:0] | cmds[w].set_flags;
            end
            if (cmds[w].load_frm) begin
                frm_n = cmds[w].new_frm;
            end else begin
                frm_n = fcsr[w][FFLAGS_BITS +: FRM_BITS];
            end
            fcsr_n[w] = {frm_n, flags_n};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr <= '0;
        end else begin
            fcsr <= fcsr_n;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FPU_BLOCKS; i++) begin
            fpu_frm[i] = fcsr[fpu_rd_wid[i]][FFLAGS_BITS +: FRM_BITS];
        end
    end

endmodule

//--- csr_read_mux.sv
// Combinational CSR read decode, split into read-only and read-write data
`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic                            read_enable,
    input  wid_t                            read_wid,
    input  csr_addr_t                       read_addr,
    input  fcsr_t        [NUM_WARPS-1:0]    fcsr,
    input  perf_ctr_t                       cycles,
    input  perf_ctr_t                       instret,
    input  warp_mask_t                      active_warps,
    input  thread_mask_t [NUM_WARPS-1:0]    thread_masks,
    output csr_word_t                       read_data_ro,
    output csr_word_t                       read_data_rw,
    output logic                            read_error
);

    logic  addr_valid;
    logic  in_mpm_lo;
    logic  in_mpm_hi;
    fcsr_t fcsr_sel;

    assign fcsr_sel = fcsr[read_wid];

    assign in_mpm_lo = (read_addr >= CSR_MPM_USER)
                    && (read_addr < CSR_MPM_USER + MPM_WINDOW);
    assign in_mpm_hi = (read_addr >= CSR_MPM_USER_H)
                    && (read_addr < CSR_MPM_USER_H + MPM_WINDOW);

    always_comb begin
        read_data_ro = '0;
        read_data_rw = '0;
        addr_valid   = 1'b1;
        case (read_addr)
            CSR_MVENDORID:   read_data_ro = VENDOR_ID;
            CSR_MARCHID:     read_data_ro = ARCH_ID;
            CSR_MIMPID:      read_data_ro = IMPL_ID;
            CSR_MISA:        read_data_ro = MISA_VALUE;

            CSR_FFLAGS:      read_data_rw = csr_word_t'(fcsr_sel[FFLAGS_BITS-1:0]);
            CSR_FRM:         read_data_rw = csr_word_t'(fcsr_sel[FFLAGS_BITS +: FRM_BITS]);
            CSR_FCSR:        read_data_rw = csr_word_t'(fcsr_sel);

            CSR_WARP_ID:     read_data_ro = csr_word_t'(read_wid);
            CSR_CORE_ID:     read_data_ro = csr_word_t'(CORE_ID);
            CSR_WARP_MASK:   read_data_ro = csr_word_t'(active_warps);
            CSR_THREAD_MASK: read_data_ro = csr_word_t'(thread_masks[read_wid]);
            CSR_NUM_THREADS: read_data_ro = csr_word_t'(NUM_THREADS);
            CSR_NUM_WARPS:   read_data_ro = csr_word_t'(NUM_WARPS);
            CSR_NUM_CORES:   read_data_ro = csr_word_t'(NUM_CORES_TOTAL);

            // High halves carry the upper counter bits zero-extended
            CSR_MCYCLE:      read_data_ro = cycles[XLEN-1:0];
            CSR_MCYCLE_H:    read_data_ro = csr_word_t'(cycles[PERF_CTR_BITS-1:XLEN]);
            CSR_MINSTRET:    read_data_ro = instret[XLEN-1:0];
            CSR_MINSTRET_H:  read_data_ro = csr_word_t'(instret[PERF_CTR_BITS-1:XLEN]);

            CSR_SATP,
            CSR_MSTATUS,
            CSR_MNSTATUS,
            CSR_MEDELEG,
            CSR_MIDELEG,
            CSR_MIE,
            CSR_MTVEC,
            CSR_MEPC,
            CSR_PMPCFG0,
            CSR_PMPADDR0:    read_data_ro = '0;

            default: begin
                // Counter windows stay addressable and read zero
                addr_valid = in_mpm_lo || in_mpm_hi;
            end
        endcase
    end

    assign read_error = read_enable && !addr_valid;

endmodule

//--- csr_data.sv
// CSR data block of one GPU core that joins the fcsr update, storage and read paths
`timescale 1ns/1ps

module csr_data import csr_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic                                clk,
    input  logic                                reset,

    input  csr_write_t                          csr_wr,
    input  fpu_flags_t   [NUM_FPU_BLOCKS-1:0]   fpu_flags,
    input  wid_t         [NUM_FPU_BLOCKS-1:0]   fpu_rd_wid,
    output frm_t         [NUM_FPU_BLOCKS-1:0]   fpu_frm,

    input  logic                                read_enable,
    input  wid_t                                read_wid,
    input  csr_addr_t                           read_addr,
    output csr_word_t                           read_data_ro,
    output csr_word_t                           read_data_rw,

    input  perf_ctr_t                           cycles,
    input  perf_ctr_t                           instret,
    input  warp_mask_t                          active_warps,
    input  thread_mask_t [NUM_WARPS-1:0]        thread_masks,

    output logic                                read_error,
    output logic                                write_error
);

    fcsr_cmd_t [NUM_WARPS-1:0] cmds;
    fcsr_t     [NUM_WARPS-1:0] fcsr;

    fcsr_update u_update (
        .csr_wr      (csr_wr),
        .fpu_flags   (fpu_flags),
        .cmds        (cmds),
        .write_error (write_error)
    );

    fcsr_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .cmds        (cmds),
        .fpu_rd_wid  (fpu_rd_wid),
        .fcsr        (fcsr),
        .fpu_frm     (fpu_frm)
    );

    csr_read_mux #(
        .CORE_ID (CORE_ID)
    ) u_read_mux (
        .read_enable  (read_enable),
        .read_wid     (read_wid),
        .read_addr    (read_addr),
        .fcsr         (fcsr),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw),
        .read_error   (read_error)
    );

endmodule

//--- tb_csr_data.sv
// Self-checking testbench for csr_data that runs as the simulation top from the file list
`timescale 1ns/1ps

module tb_csr_data import csr_pkg::*; ();

    localparam int PERIOD      = 100;
    localparam int RAND_CYCLES = 64;
    localparam int TEST_CYCLES = 8 + 14 + 2 * (RAND_CYCLES + 2) + 62 + 40;
    localparam int MARGIN      = 100;

    localparam csr_addr_t RO_ADDRS [15] = '{
        CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MISA, CSR_WARP_ID, CSR_CORE_ID,
        CSR_WARP_MASK, CSR_THREAD_MASK, CSR_NUM_THREADS, CSR_NUM_WARPS, CSR_NUM_CORES,
        CSR_MCYCLE, CSR_MCYCLE_H, CSR_MINSTRET, CSR_MINSTRET_H
    };
    localparam csr_addr_t STUB_ADDRS [10] = '{
        CSR_SATP, CSR_MSTATUS, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE,
        CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0, CSR_MNSTATUS
    };
    localparam csr_addr_t BAD_ADDRS [8] = '{
        12'h000, 12'h004, 12'h306, 12'h7C0, 12'hB20, 12'hBA0, 12'hCC0, 12'hFFF
    };
    localparam csr_addr_t MPM_ADDRS [6] = '{
        12'hB03, 12'hB05, 12'hB1F, 12'hB83, 12'hB9A, 12'hB9F
    };

    logic                                clk;
    logic                                reset;
    csr_write_t                          csr_wr;
    fpu_flags_t   [NUM_FPU_BLOCKS-1:0]   fpu_flags;
    wid_t         [NUM_FPU_BLOCKS-1:0]   fpu_rd_wid;
    frm_t         [NUM_FPU_BLOCKS-1:0]   fpu_frm;
    logic                                read_enable;
    wid_t                                read_wid;
    csr_addr_t                           read_addr;
    csr_word_t                           read_data_ro;
    csr_word_t                           read_data_rw;
    perf_ctr_t                           cycles;
    perf_ctr_t                           instret;
    warp_mask_t                          active_warps;
    thread_mask_t [NUM_WARPS-1:0]        thread_masks;
    logic                                read_error;
    logic                                write_error;

    fcsr_t       model [NUM_WARPS];
    int          errors;
    int          test_errors;
    int          tests_run;
    int unsigned seed_val;

    csr_data #(.CORE_ID(3)) DUT (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic is_fp(csr_addr_t a);
        return (a == CSR_FFLAGS) || (a == CSR_FRM) || (a == CSR_FCSR);
    endfunction

    function automatic logic is_stub(csr_addr_t a);
        foreach (STUB_ADDRS[i]) begin
            if (a == STUB_ADDRS[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic known_addr(csr_addr_t a);
        if (a >= CSR_MPM_USER && a < CSR_MPM_USER + 32) return 1'b1;
        if (a >= CSR_MPM_USER_H && a < CSR_MPM_USER_H + 32) return 1'b1;
        foreach (RO_ADDRS[i]) begin
            if (a == RO_ADDRS[i]) return 1'b1;
        end
        return is_fp(a) || is_stub(a);
    endfunction

    function automatic csr_word_t ro_value(csr_addr_t a, wid_t w);
        case (a)
            CSR_MVENDORID:   return VENDOR_ID;
            CSR_MARCHID:     return ARCH_ID;
            CSR_MIMPID:      return IMPL_ID;
            CSR_MISA:        return 32'h4000_1120;
            CSR_WARP_ID:     return 32'(w);
            CSR_CORE_ID:     return 32'd3;
            CSR_WARP_MASK:   return 32'(active_warps);
            CSR_THREAD_MASK: return 32'(thread_masks[w]);
            CSR_NUM_THREADS: return 32'd4;
            CSR_NUM_WARPS:   return 32'd4;
            CSR_NUM_CORES:   return 32'd4;
            CSR_MCYCLE:      return cycles[31:0];
            CSR_MCYCLE_H:    return {20'd0, cycles[43:32]};
            CSR_MINSTRET:    return instret[31:0];
            CSR_MINSTRET_H:  return {20'd0, instret[43:32]};
            default:         return '0;
        endcase
    endfunction

    function automatic csr_word_t rw_value(csr_addr_t a, wid_t w);
        case (a)
            CSR_FFLAGS: return {27'd0, model[w][4:0]};
            CSR_FRM:    return {29'd0, model[w][7:5]};
            CSR_FCSR:   return {24'd0, model[w]};
            default:    return '0;
        endcase
    endfunction

    // Next fcsr of one warp from this cycle's write and flag reports
    function automatic fcsr_t next_fcsr(int w);
        fflags_t flags;
        frm_t    frm;
        logic    hit;
        flags = model[w][4:0];
        frm   = model[w][7:5];
        hit   = csr_wr.enable && (csr_wr.wid == wid_t'(w));
        for (int f = 0; f < NUM_FPU_BLOCKS; f++) begin
            if (fpu_flags[f].valid && fpu_flags[f].wid == wid_t'(w)) flags |= fpu_flags[f].fflags;
        end
        if (hit && (csr_wr.addr == CSR_FFLAGS || csr_wr.addr == CSR_FCSR)) begin
            flags = csr_wr.data[4:0];
        end
        if (hit && csr_wr.addr == CSR_FRM) frm = csr_wr.data[2:0];
        if (hit && csr_wr.addr == CSR_FCSR) frm = csr_wr.data[7:5];
        return {frm, flags};
    endfunction

    always @(posedge clk) begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            model[w] <= reset ? fcsr_t'(0) : next_fcsr(w);
        end
    end

    // Outputs are settled at the falling edge
    assert property (@(negedge clk) disable iff (reset)
        read_enable |-> read_data_rw == rw_value(read_addr, read_wid))
    else begin
        errors = errors + 1;
        $display("Mismatch read_data_rw: got %h expected %h", read_data_rw,
                 rw_value(read_addr, read_wid));
    end

    assert property (@(negedge clk) disable iff (reset)
        read_enable |-> read_data_ro == ro_value(read_addr, read_wid))
    else begin
        errors = errors + 1;
        $display("Mismatch read_data_ro: got %h expected %h", read_data_ro,
                 ro_value(read_addr, read_wid));
    end

    assert property (@(negedge clk) disable iff (reset)
        read_error == (read_enable && !known_addr(read_addr)))
    else begin
        errors = errors + 1;
        $display("Mismatch read_error: got %h expected %h at address %h", read_error,
                 read_enable && !known_addr(read_addr), read_addr);
    end

    assert property (@(negedge clk) disable iff (reset)
        write_error == (csr_wr.enable && !is_fp(csr_wr.addr) && !is_stub(csr_wr.addr)))
    else begin
        errors = errors + 1;
        $display("Mismatch write_error: got %h expected %h at address %h", write_error,
                 csr_wr.enable && !is_fp(csr_wr.addr) && !is_stub(csr_wr.addr), csr_wr.addr);
    end

    for (genvar i = 0; i < NUM_FPU_BLOCKS; i++) begin : g_frm_check
        assert property (@(negedge clk) disable iff (reset)
            fpu_frm[i] == model[fpu_rd_wid[i]][7:5])
        else begin
            errors = errors + 1;
            $display("Mismatch fpu_frm[%0d]: got %h expected %h", i, fpu_frm[i],
                     model[fpu_rd_wid[i]][7:5]);
        end
    end

    task automatic cycle_start();
        @(posedge clk);
        csr_wr      <= '0;
        fpu_flags   <= '0;
        read_enable <= 1'b1;
    endtask

    task automatic end_test(string name);
        cycle_start();
        @(negedge clk);
        #1;
        tests_run = tests_run + 1;
        $display("%s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic random_write(wid_t w, csr_addr_t a);
        csr_wr.enable <= 1'b1;
        csr_wr.wid    <= w;
        csr_wr.addr   <= a;
        csr_wr.data   <= $urandom;
    endtask

    function automatic csr_addr_t fp_addr(int unsigned k);
        return (k % 3 == 0) ? CSR_FFLAGS : (k % 3 == 1) ? CSR_FRM : CSR_FCSR;
    endfunction

    task automatic read_all_fcsr();
        for (int w = 0; w < NUM_WARPS; w++) begin
            cycle_start();
            read_wid  <= wid_t'(w);
            read_addr <= CSR_FCSR;
        end
    endtask

    task automatic reset_state_reads();
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int k = 0; k < 3; k++) begin
                cycle_start();
                read_wid   <= wid_t'(w);
                read_addr  <= fp_addr(k);
                fpu_rd_wid <= {wid_t'(w), wid_t'(3 - w)};
            end
        end
        end_test("reset state");
    endtask

    task automatic write_readback();
        wid_t prev_wid;
        prev_wid = '0;
        repeat (RAND_CYCLES) begin
            cycle_start();
            read_wid   <= ($urandom % 2) ? prev_wid : wid_t'($urandom);
            read_addr  <= fp_addr($urandom);
            fpu_rd_wid <= {wid_t'($urandom), wid_t'($urandom)};
            prev_wid = wid_t'($urandom);
            random_write(prev_wid, fp_addr($urandom));
        end
        end_test("csr writes");
    endtask

    task automatic flag_accumulation();
        wid_t w0;
        wid_t w1;
        repeat (RAND_CYCLES) begin
            cycle_start();
            w0 = wid_t'($urandom);
            // Both units on the same warp about a third of the time
            w1 = ($urandom % 3 == 0) ? w0 : wid_t'($urandom);
            fpu_flags[0] <= '{valid: ($urandom % 4 != 0), wid: w0, fflags: fflags_t'($urandom)};
            fpu_flags[1] <= '{valid: ($urandom % 4 != 0), wid: w1, fflags: fflags_t'($urandom)};
            if ($urandom % 4 == 0) random_write(w0, fp_addr($urandom));
            read_wid   <= wid_t'($urandom);
            read_addr  <= fp_addr($urandom);
            fpu_rd_wid <= {w1, w0};
        end
        end_test("flag accumulation");
    endtask

    task automatic read_only_values();
        foreach (RO_ADDRS[i]) begin
            repeat (4) begin
                cycle_start();
                cycles       <= {12'($urandom), 32'($urandom)};
                instret      <= {12'($urandom), 32'($urandom)};
                active_warps <= warp_mask_t'($urandom);
                thread_masks <= 16'($urandom);
                read_wid     <= wid_t'($urandom);
                read_addr    <= RO_ADDRS[i];
            end
        end
        end_test("read-only csrs");
    endtask

    task automatic address_checks();
        foreach (BAD_ADDRS[i]) begin
            cycle_start();
            read_addr <= BAD_ADDRS[i];
        end
        cycle_start();
        read_enable <= 1'b0;
        foreach (STUB_ADDRS[i]) begin
            cycle_start();
            read_addr <= STUB_ADDRS[i];
            random_write(wid_t'(i), STUB_ADDRS[i]);
        end
        foreach (MPM_ADDRS[i]) begin
            cycle_start();
            read_addr <= MPM_ADDRS[i];
        end
        foreach (BAD_ADDRS[i]) begin
            cycle_start();
            random_write(wid_t'(i), BAD_ADDRS[i]);
            read_wid  <= wid_t'(i);
            read_addr <= CSR_FCSR;
        end
        read_all_fcsr();
        end_test("address checking");
    endtask

    initial begin
        #(PERIOD * (TEST_CYCLES + MARGIN));
        $display("Timeout: the tests did not finish within the watchdog limit");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed_val     = $urandom(32'hb8a2);
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        reset        = 1'b1;
        csr_wr       = '0;
        fpu_flags    = '0;
        fpu_rd_wid   = '0;
        read_enable  = 1'b0;
        read_wid     = '0;
        read_addr    = '0;
        cycles       = '0;
        instret      = '0;
        active_warps = '0;
        thread_masks = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        reset_state_reads();
        write_readback();
        flag_accumulation();
        read_only_values();
        address_checks();

        $display("Summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- csr_data.f
csr_pkg.sv
fcsr_update.sv
fcsr_regfile.sv
csr_read_mux.sv
csr_data.sv
tb_csr_data.sv

//--- Bender.yml
package:
  name: csr_data

sources:
  - csr_pkg.sv
  - fcsr_update.sv
  - fcsr_regfile.sv
  - csr_read_mux.sv
  - csr_data.sv
  - target: simulation
    files:
      - tb_csr_data.sv
